// ==== source/prefetch_pkg.sv ====
`default_nettype none

package prefetch_pkg;

    // Line geometry.
    localparam int ADDR_BITS      = 16;
    localparam int WORD_BITS      = 16;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;
    localparam int OFFSET_BITS    = 4;   // Byte offset inside a line.
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0]      addr_t;       // Byte address.
    typedef logic [LINE_BITS-1:0]      line_t;       // One cache line.
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;  // Line number.

    // Instruction cache side.
    typedef struct packed {
        logic  read;
        addr_t address;
    } icache_req_t;

    typedef struct packed {
        logic  resp;
        line_t rdata;
    } icache_rsp_t;

    // L2 and physical memory side, same shape on both paths.
    typedef struct packed {
        logic       read;
        line_addr_t address;
    } mem_req_t;

    typedef struct packed {
        logic  resp;
        line_t rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        PROCESS_REQUEST = 2'd0,
        FETCH_LINE      = 2'd1,
        PREFETCH_LINE   = 2'd2
    } pf_state_t;

endpackage : prefetch_pkg

`default_nettype wire

// ==== source/prefetch_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetch_controller (
    input  wire  clk,
    input  wire  i_rst,

    // Request side.
    input  wire  i_read,
    input  wire  i_pf_hit,
    output logic o_icache_resp,

    // Buffer strobes.
    output logic o_load_pf_addr,
    output logic o_load_pf_line,
    output logic o_rdata_sel,

    // Memory paths.
    input  wire  i_l2_resp,
    output logic o_l2_read,
    input  wire  i_pmem_resp,
    output logic o_pmem_read
);

    import prefetch_pkg::*;

    pf_state_t state;
    pf_state_t next_state;

    logic req_hit;
    logic req_miss;

    assign req_hit  = i_read & i_pf_hit;
    assign req_miss = i_read & ~i_pf_hit;

    // Outputs and next state come from one decode of the current state.
    always_comb begin
        next_state     = state;
        o_load_pf_addr = 1'b0;
        o_load_pf_line = 1'b0;
        o_rdata_sel    = 1'b0;
        o_icache_resp  = 1'b0;
        o_l2_read      = 1'b0;
        o_pmem_read    = 1'b0;

        case (state)
            PROCESS_REQUEST: begin
                if (req_hit) begin
                    o_rdata_sel   = 1'b1;  // Answer from the buffer.
                    o_icache_resp = 1'b1;
                end else if (req_miss) begin
                    // Next line address is captured on entry to the fetch.
                    o_load_pf_addr = 1'b1;
                    next_state     = FETCH_LINE;
                end
            end

            FETCH_LINE: begin
                o_l2_read = 1'b1;
                if (i_l2_resp) begin
                    o_icache_resp = 1'b1;  // L2 data goes straight through.
                    next_state    = PREFETCH_LINE;
                end
            end

            PREFETCH_LINE: begin
                o_pmem_read = 1'b1;
                if (i_pmem_resp) begin
                    // Store only once the full line is on the bus.
                    o_load_pf_line = 1'b1;
                    if (req_miss) begin
                        o_load_pf_addr = 1'b1;
                        next_state     = FETCH_LINE;
                    end else begin
                        next_state = PROCESS_REQUEST;  // Idle, or served next cycle.
                    end
                end
            end

            default: begin
                next_state = PROCESS_REQUEST;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= PROCESS_REQUEST;
        end else begin
            state <= next_state;
        end
    end

endmodule : prefetch_controller

`default_nettype wire

// ==== source/prefetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer (
    input  wire                     clk,
    input  wire                     i_rst,

    input  prefetch_pkg::addr_t     i_address,
    input  wire                     i_load_pf_addr,
    input  wire                     i_load_pf_line,
    input  wire                     i_rdata_sel,
    input  prefetch_pkg::line_t     i_l2_rdata,
    input  prefetch_pkg::line_t     i_pmem_rdata,

    output logic                    o_pf_hit,
    output prefetch_pkg::line_addr_t o_pf_line_addr,
    output prefetch_pkg::line_t     o_rdata
);

    import prefetch_pkg::*;

    line_addr_t req_line;
    line_addr_t pf_line_addr;
    line_t      pf_line;
    logic       pf_valid;
    logic       line_match;

    // Drop the byte offset; all compares work on line numbers.
    assign req_line = i_address[ADDR_BITS-1:OFFSET_BITS];

    // Address and data registers.
    always_ff @(posedge clk) begin
        if (i_load_pf_addr) begin
            pf_line_addr <= req_line + line_addr_t'(1);  // Next sequential line.
        end
        if (i_load_pf_line) begin
            pf_line <= i_pmem_rdata;
        end
    end

    // A new target address invalidates the old line, even when a
    // stale line lands in the same cycle.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pf_valid <= 1'b0;
        end else if (i_load_pf_addr) begin
            pf_valid <= 1'b0;
        end else if (i_load_pf_line) begin
            pf_valid <= 1'b1;
        end
    end

    assign line_match = (pf_line_addr == req_line);

    // A line being written this cycle counts as present, so the FSM can
    // decide where to go as the prefetch completes.
    assign o_pf_hit = (pf_valid | i_load_pf_line) & line_match;

    assign o_pf_line_addr = pf_line_addr;

    assign o_rdata = i_rdata_sel ? pf_line : i_l2_rdata;  // Buffer or L2 pass-through.

endmodule : prefetch_buffer

`default_nettype wire

// ==== source/prefetcher_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetcher_top (
    input  wire                      clk,
    input  wire                      i_rst,

    // Instruction cache.
    input  prefetch_pkg::icache_req_t i_icache_req,
    output prefetch_pkg::icache_rsp_t o_icache_rsp,

    // L2 path, demand fetches.
    output prefetch_pkg::mem_req_t    o_l2_req,
    input  prefetch_pkg::mem_rsp_t    i_l2_rsp,

    // Physical memory path, prefetches.
    output prefetch_pkg::mem_req_t    o_pmem_req,
    input  prefetch_pkg::mem_rsp_t    i_pmem_rsp
);

    import prefetch_pkg::*;

    logic       pf_hit;
    logic       load_pf_addr;
    logic       load_pf_line;
    logic       rdata_sel;
    logic       icache_resp;
    logic       l2_read;
    logic       pmem_read;
    line_addr_t pf_line_addr;
    line_t      rdata;

    prefetch_controller u_controller (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_read         (i_icache_req.read),
        .i_pf_hit       (pf_hit),
        .o_icache_resp  (icache_resp),
        .o_load_pf_addr (load_pf_addr),
        .o_load_pf_line (load_pf_line),
        .o_rdata_sel    (rdata_sel),
        .i_l2_resp      (i_l2_rsp.resp),
        .o_l2_read      (l2_read),
        .i_pmem_resp    (i_pmem_rsp.resp),
        .o_pmem_read    (pmem_read)
    );

    prefetch_buffer u_buffer (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_address      (i_icache_req.address),
        .i_load_pf_addr (load_pf_addr),
        .i_load_pf_line (load_pf_line),
        .i_rdata_sel    (rdata_sel),
        .i_l2_rdata     (i_l2_rsp.rdata),
        .i_pmem_rdata   (i_pmem_rsp.rdata),
        .o_pf_hit       (pf_hit),
        .o_pf_line_addr (pf_line_addr),
        .o_rdata        (rdata)
    );

    // Response back to the cache.
    assign o_icache_rsp.resp  = icache_resp;
    assign o_icache_rsp.rdata = rdata;

    // Demand fetch asks L2 for the line the cache is holding up.
    assign o_l2_req.read    = l2_read;
    assign o_l2_req.address = i_icache_req.address[ADDR_BITS-1:OFFSET_BITS];

    // Prefetch goes to memory for the stored next line.
    assign o_pmem_req.read    = pmem_read;
    assign o_pmem_req.address = pf_line_addr;

endmodule : prefetcher_top

`default_nettype wire

// ==== dv/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;  // 8 ns period.
    end

    // Reset spans three rising edges and drops on a falling edge.
    initial begin
        o_rst = 1'b1;
        repeat (3) @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule : clock_gen

`default_nettype wire

// ==== dv/prefetcher_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetcher_checker (
    input wire                       clk,
    input wire                       i_rst,
    input prefetch_pkg::icache_rsp_t i_icache_rsp,
    input prefetch_pkg::mem_req_t    i_l2_req,
    input prefetch_pkg::mem_rsp_t    i_l2_rsp,
    input prefetch_pkg::mem_req_t    i_pmem_req,
    input prefetch_pkg::mem_rsp_t    i_pmem_rsp
);

    import prefetch_pkg::*;

    logic failed = 1'b0;  // Sticky, read by the testbench.

    // Only one memory path is busy at a time.
    one_path_busy: assert property (@(posedge clk) disable iff (i_rst)
        !(i_l2_req.read && i_pmem_req.read))
        else begin
            failed = 1'b1;
            $error("L2 and memory reads are high together");
        end

    l2_addr_held: assert property (@(posedge clk) disable iff (i_rst)
        i_l2_req.read && !i_l2_rsp.resp |=> i_l2_req.read && $stable(i_l2_req.address))
        else begin
            failed = 1'b1;
            $error("L2 read dropped or its address moved before resp");
        end

    pmem_addr_held: assert property (@(posedge clk) disable iff (i_rst)
        i_pmem_req.read && !i_pmem_rsp.resp |=> i_pmem_req.read && $stable(i_pmem_req.address))
        else begin
            failed = 1'b1;
            $error("Memory read dropped or its address moved before resp");
        end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(i_rst) |-> !i_l2_req.read && !i_pmem_req.read && !i_icache_rsp.resp)
        else begin
            failed = 1'b1;
            $error("Read or resp active in the first cycle after reset");
        end

    // The prefetch always targets the line after the demand fetch.
    next_line_target: assert property (@(posedge clk) disable iff (i_rst)
        $rose(i_pmem_req.read) |->
            i_pmem_req.address == line_addr_t'($past(i_l2_req.address) + 1))
        else begin
            failed = 1'b1;
            $error("Memory address is not the last L2 line plus one");
        end

endmodule : prefetcher_checker

bind prefetcher_top prefetcher_checker u_checker (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_icache_rsp (o_icache_rsp),
    .i_l2_req     (o_l2_req),
    .i_l2_rsp     (i_l2_rsp),
    .i_pmem_req   (o_pmem_req),
    .i_pmem_rsp   (i_pmem_rsp)
);

`default_nettype wire

// ==== dv/prefetcher_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetcher_tb;

    import prefetch_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic        clk;
    logic        rst;
    icache_req_t icache_req;
    icache_rsp_t icache_rsp;
    mem_req_t    l2_req;
    mem_rsp_t    l2_rsp;
    mem_req_t    pmem_req;
    mem_rsp_t    pmem_rsp;

    int         seed = 32'hd84671dd;
    int         l2_wait = 0;
    int         pmem_wait = 0;
    int         pmem_slow = 0;    // Fixed memory latency when nonzero.
    int         l2_count = 0;
    int         pmem_count = 0;
    int         exp_miss_count = 0;
    int         rsp_count = 0;
    logic       have_miss = 1'b0;
    line_addr_t last_miss;
    line_addr_t demand_line;     // Line of the read most recently issued.
    line_addr_t l2_line;
    line_addr_t exp_line;
    line_addr_t expected_q[$];   // Lines of reads still waiting for resp.

    clock_gen u_clock_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    prefetcher_top DUT (
        .clk          (clk),
        .i_rst        (rst),
        .i_icache_req (icache_req),
        .o_icache_rsp (icache_rsp),
        .o_l2_req     (l2_req),
        .i_l2_rsp     (l2_rsp),
        .o_pmem_req   (pmem_req),
        .i_pmem_rsp   (pmem_rsp)
    );

    // Expected line content, each word a mix of line number and word index.
    function automatic line_t line_data(input line_addr_t line_num);
        line_t data;
        data = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            data[w*WORD_BITS +: WORD_BITS] = {line_num, 4'(w)} ^ {4'(w + 5), line_num} ^ 16'h6b2d;
        end
        return data;
    endfunction

    function automatic int next_latency();
        return 1 + int'($unsigned($random(seed)) % 6);  // 1 to 6 cycles.
    endfunction

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on the first failure.");
    endtask

    task automatic check_equal(input string what, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s mismatch, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // L2 and memory models, both answer a held read after some cycles.
    always @(negedge clk) begin
        l2_rsp   = '0;
        pmem_rsp = '0;
        if (rst || !l2_req.read) begin
            l2_wait = 0;
        end else begin
            if (l2_wait == 0) begin
                l2_wait  = next_latency();
                l2_count = l2_count + 1;
                l2_line  = demand_line;  // Line of the read being served.
                check_equal("L2 request line", line_t'(l2_req.address), line_t'(l2_line));
            end
            l2_wait = l2_wait - 1;
            if (l2_wait == 0) begin
                l2_rsp.resp  = 1'b1;
                l2_rsp.rdata = line_data(l2_req.address);
            end
        end
        if (rst || !pmem_req.read) begin
            pmem_wait = 0;
        end else begin
            if (pmem_wait == 0) begin
                pmem_wait  = (pmem_slow != 0) ? pmem_slow : next_latency();
                pmem_count = pmem_count + 1;
                check_equal("memory request line", line_t'(pmem_req.address),
                            line_t'(line_addr_t'(l2_line + 1)));
            end
            pmem_wait = pmem_wait - 1;
            if (pmem_wait == 0) begin
                pmem_rsp.resp  = 1'b1;
                pmem_rsp.rdata = line_data(pmem_req.address);
            end
        end
    end

    // Every cache response is compared with the oldest outstanding read.
    always @(posedge clk) begin
        if (!rst && icache_rsp.resp) begin
            if (expected_q.size() == 0) begin
                $display("The DUT answered with no read outstanding at %0t ns.", $time);
                abort_run();
            end else begin
                exp_line = expected_q.pop_front();
                check_equal("response data", icache_rsp.rdata, line_data(exp_line));
                check_equal("response while prefetch busy", line_t'(pmem_req.read), '0);
                rsp_count = rsp_count + 1;
            end
        end
    end

    always @(negedge clk) begin
        if (DUT.u_checker.failed) begin
            $display("A protocol assertion of the bound checker failed.");
            abort_run();
        end
    end

    // Drives a read at the current falling edge, returns after its resp.
    task automatic read_line(input line_addr_t line_num, input logic [3:0] offset);
        int   start;
        int   waited;
        logic hit;
        // Hits start no prefetch, so only the line after the last miss can hit.
        hit = have_miss && (line_num == line_addr_t'(last_miss + 1));
        if (!hit) begin
            have_miss      = 1'b1;
            last_miss      = line_num;
            exp_miss_count = exp_miss_count + 1;
        end
        expected_q.push_back(line_num);
        demand_line = line_num;
        start  = rsp_count;
        waited = 0;
        icache_req.read    = 1'b1;
        icache_req.address = {line_num, offset};
        while (rsp_count == start) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("Timeout: no response to the read of line %h.", line_num);
                abort_run();
            end
        end
    endtask

    task automatic go_idle(input int cycles);
        icache_req.read = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    // Lets the last prefetch finish, then compares request counts.
    task automatic settle_and_count(input string what);
        int waited;
        go_idle(2);
        waited = 0;
        while (l2_req.read || pmem_req.read) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("Timeout: memory paths still busy after %s.", what);
                abort_run();
            end
        end
        check_equal({what, ", L2 requests"}, line_t'(l2_count), line_t'(exp_miss_count));
        check_equal({what, ", memory requests"}, line_t'(pmem_count), line_t'(exp_miss_count));
    endtask

    initial begin
        int         waited;
        int         r;
        line_addr_t pick;
        icache_req = '0;
        l2_rsp     = '0;
        pmem_rsp   = '0;
        waited     = 0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                $display("Timeout: reset never released.");
                abort_run();
            end
        end
        @(negedge clk);

        // First read misses, its next line comes from the buffer.
        read_line(12'h040, 4'h0);
        read_line(12'h041, 4'h6);
        settle_and_count("miss then next line");

        for (int i = 0; i < 4; i++) begin
            read_line(line_addr_t'(12'h100 + i), 4'h2);  // Miss and hit alternate.
        end
        settle_and_count("sequential stream");

        read_line(12'h200, 4'h0);
        read_line(12'h200, 4'h8);  // Same line again, misses and restarts the prefetch.
        settle_and_count("repeated miss line");

        // Reads arrive while a slow prefetch is still waiting.
        pmem_slow = 10;
        read_line(12'h300, 4'h0);
        read_line(12'h301, 4'h4);
        read_line(12'h350, 4'h0);
        read_line(12'h3a0, 4'hc);
        settle_and_count("reads during slow prefetch");
        pmem_slow = 0;

        for (int i = 0; i < 60; i++) begin
            r = $random(seed);
            if (have_miss && r[1:0] == 2'b01) begin
                pick = line_addr_t'(last_miss + 1);
            end else if (have_miss && r[1:0] == 2'b10) begin
                pick = last_miss;
            end else begin
                pick = r[27:16];
            end
            go_idle(int'(r[9:8]));
            read_line(pick, r[7:4]);
        end
        settle_and_count("random reads");

        if (!DUT.u_checker.failed) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("The bound protocol checker flagged a failure.");
            abort_run();
        end
    end

endmodule : prefetcher_tb

`default_nettype wire

// ==== prefetch.f ====
source/prefetch_pkg.sv
source/prefetch_controller.sv
source/prefetch_buffer.sv
source/prefetcher_top.sv
dv/clock_gen.sv
dv/prefetcher_checker.sv
dv/prefetcher_tb.sv

// ==== Makefile ====
# Verilator simulation of the next-line prefetcher.

TOP := prefetcher_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f prefetch.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "TEST PASS" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
